// File: Makefile
# Verilator build for the Ethernet MAC frame engine

VERILATOR ?= verilator
TOP       ?= tb_eth_mac
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: common/byte_stream_if.sv
/* Byte stream with credit flow control
   Initiator sends one beat per credit, target pulses credit per freed slot */
interface byte_stream_if
   import eth_pkg::*;
(
   input logic clk
);

   logic       valid;
   byte_beat_t beat;
   logic       credit;  // One pulse per slot freed

   modport initiator (
      input  clk,
      output valid,
      output beat,
      input  credit
   );

   modport target (
      input  clk,
      input  valid,
      input  beat,
      output credit
   );

endinterface

// File: common/eth_pkg.sv
/* Ethernet MAC shared definitions
   Frame constants, the byte stream beat and the CRC-32 byte update */
package eth_pkg;

   // Frame store sizing
   localparam int FRAME_STORE_DEPTH  = 256;
   localparam int FRAME_STORE_ADDR_W = $clog2(FRAME_STORE_DEPTH);
   localparam int CREDIT_W           = FRAME_STORE_ADDR_W + 1;  // Counts 0 up to full depth
   localparam int MAX_FRAME_BYTES    = 128;                     // Largest accepted payload
   localparam int HOST_RX_CREDITS    = 4;

   // MII framing
   localparam int         PREAMBLE_NIBBLES = 15;
   localparam logic [3:0] PREAMBLE_VALUE   = 4'h5;
   localparam logic [3:0] SFD_NIBBLE       = 4'hD;
   localparam int         IPG_NIBBLES      = 24;
   localparam int         FCS_NIBBLES      = 8;
   localparam int         RX_DELAY_BYTES   = 5;  // FCS plus one payload byte

   // Reflected CRC-32
   localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

   typedef struct packed {
      logic [7:0] data;
      logic       last;  // Final byte of a frame
   } byte_beat_t;

   // One byte through the CRC register, LSB first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
      return c;
   endfunction

endpackage

// File: eth_rx/eth_mii_rx.sv
/* MII receiver
   Finds the SFD, rebuilds bytes, strips and checks the FCS */
module eth_mii_rx
   import eth_pkg::*;
(
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [3:0]       mii_rxd_i,
   input  logic             mii_rx_dv_i,
   byte_stream_if.initiator dst_if,
   output logic             rx_frame_ok_o,
   output logic             rx_crc_err_o,
   output logic             rx_drop_o
);

   typedef enum logic [1:0] {
      S_HUNT,
      S_PRE,
      S_DATA,
      S_SKIP
   } rx_state_t;

   rx_state_t           state_q;
   logic                hi_phase_q;
   logic [3:0]          lo_nib_q;
   logic [7:0]          dly_q [RX_DELAY_BYTES];  // Index 0 is the newest byte
   logic [2:0]          fill_q;
   logic [31:0]         crc_q;
   logic [CREDIT_W-1:0] cred_q;       // Free slots in the receive store
   logic                drop_pend_q;  // Frame skipped for lack of room
   logic                push_q;
   byte_beat_t          push_beat_q;
   logic                ok_q;
   logic                err_q;
   logic                drop_q;
   logic [7:0]          rx_byte;
   logic                byte_done;
   logic                frame_end;
   logic                dly_full;
   logic                frame_good;

   assign rx_byte    = {mii_rxd_i, lo_nib_q};
   assign byte_done  = (state_q == S_DATA) && mii_rx_dv_i && hi_phase_q;
   assign frame_end  = (state_q == S_DATA) && !mii_rx_dv_i;
   assign dly_full   = (fill_q == 3'(RX_DELAY_BYTES));
   assign frame_good = dly_full && (crc_q == CRC_RESIDUE);

   assign dst_if.valid  = push_q;
   assign dst_if.beat   = push_beat_q;
   assign rx_frame_ok_o = ok_q;
   assign rx_crc_err_o  = err_q;
   assign rx_drop_o     = drop_q;

   // Nibble assembly and FCS delay line
   always_ff @(posedge clk_i) begin
      if ((state_q == S_DATA) && !hi_phase_q) begin
         lo_nib_q <= mii_rxd_i;
      end
      if (byte_done) begin
         dly_q[0] <= rx_byte;
         for (int i = 1; i < RX_DELAY_BYTES; i++) begin
            dly_q[i] <= dly_q[i-1];
         end
      end
      if (byte_done || frame_end) begin
         push_beat_q <= '{data: dly_q[RX_DELAY_BYTES-1], last: frame_end};
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= S_HUNT;
         hi_phase_q  <= 1'b0;
         fill_q      <= '0;
         crc_q       <= CRC_INIT;
         cred_q      <= CREDIT_W'(FRAME_STORE_DEPTH);
         drop_pend_q <= 1'b0;
         push_q      <= 1'b0;
         ok_q        <= 1'b0;
         err_q       <= 1'b0;
         drop_q      <= 1'b0;
      end else begin
         push_q <= 1'b0;
         ok_q   <= 1'b0;
         err_q  <= 1'b0;
         drop_q <= 1'b0;

         case ({dst_if.credit, push_q})
            2'b10:   cred_q <= cred_q + 1'b1;
            2'b01:   cred_q <= cred_q - 1'b1;
            default: cred_q <= cred_q;
         endcase

         case (state_q)
            S_HUNT: begin
               drop_pend_q <= 1'b0;
               if (mii_rx_dv_i) begin
                  state_q <= (mii_rxd_i == PREAMBLE_VALUE) ? S_PRE : S_SKIP;
               end
            end
            S_PRE: begin
               if (!mii_rx_dv_i) begin
                  state_q <= S_HUNT;
               end else if (mii_rxd_i == SFD_NIBBLE) begin
                  if (cred_q >= CREDIT_W'(MAX_FRAME_BYTES)) begin  // Room for a full frame
                     hi_phase_q <= 1'b0;
                     fill_q     <= '0;
                     crc_q      <= CRC_INIT;
                     state_q    <= S_DATA;
                  end else begin
                     drop_pend_q <= 1'b1;
                     state_q     <= S_SKIP;
                  end
               end else if (mii_rxd_i != PREAMBLE_VALUE) begin
                  state_q <= S_SKIP;  // Broken preamble
               end
            end
            S_DATA: begin
               if (!mii_rx_dv_i) begin
                  push_q  <= dly_full;  // Oldest byte closes the frame
                  ok_q    <= frame_good;
                  err_q   <= !frame_good;
                  state_q <= S_HUNT;
               end else begin
                  hi_phase_q <= !hi_phase_q;
                  if (hi_phase_q) begin
                     crc_q <= crc32_byte(crc_q, rx_byte);
                     if (dly_full) begin
                        push_q <= 1'b1;
                     end else begin
                        fill_q <= fill_q + 1'b1;
                     end
                  end
               end
            end
            S_SKIP: begin
               if (!mii_rx_dv_i) begin
                  drop_q  <= drop_pend_q;
                  state_q <= S_HUNT;
               end
            end
            default: state_q <= S_HUNT;
         endcase
      end
   end

endmodule

// File: eth_tx/eth_mii_tx.sv
/* MII transmitter
   Sends preamble, SFD, payload nibbles and FCS, then holds the gap */
module eth_mii_tx
   import eth_pkg::*;
(
   input  logic          clk_i,
   input  logic          rst_n_i,
   byte_stream_if.target src_if,
   output logic [3:0]    mii_txd_o,
   output logic          mii_tx_en_o
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_PRE,
      S_SFD,
      S_DATA,
      S_FCS,
      S_GAP
   } tx_state_t;

   tx_state_t   state_q;
   logic [4:0]  cnt_q;       // Preamble, FCS and gap counter
   logic        hi_phase_q;  // High nibble goes out next
   logic [3:0]  hi_nib_q;
   logic        last_q;
   logic [31:0] crc_q;
   logic [31:0] fcs;
   byte_beat_t  buf_q;
   logic        buf_full_q;
   logic [3:0]  txd_q;
   logic        tx_en_q;
   logic        take;
   byte_beat_t  cur;

   // A byte is taken every other clock in the data phase
   assign take = (state_q == S_DATA) && !hi_phase_q;
   assign cur  = buf_full_q ? buf_q : src_if.beat;  // Bypass when the beat lands just in time
   assign fcs  = ~crc_q;

   assign src_if.credit = take;
   assign mii_txd_o     = txd_q;
   assign mii_tx_en_o   = tx_en_q;

   // One beat holding buffer
   always_ff @(posedge clk_i) begin
      if (src_if.valid && (buf_full_q || !take)) begin
         buf_q <= src_if.beat;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         buf_full_q <= 1'b0;
      end else if (src_if.valid && (buf_full_q || !take)) begin
         buf_full_q <= 1'b1;
      end else if (take) begin
         buf_full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= S_IDLE;
         cnt_q      <= '0;
         hi_phase_q <= 1'b0;
         hi_nib_q   <= '0;
         last_q     <= 1'b0;
         crc_q      <= CRC_INIT;
         txd_q      <= '0;
         tx_en_q    <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (buf_full_q) begin
                  txd_q   <= PREAMBLE_VALUE;  // First preamble nibble
                  tx_en_q <= 1'b1;
                  cnt_q   <= 5'd1;
                  crc_q   <= CRC_INIT;
                  state_q <= S_PRE;
               end
            end
            S_PRE: begin
               txd_q <= PREAMBLE_VALUE;
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 5'(PREAMBLE_NIBBLES - 1)) begin
                  state_q <= S_SFD;
               end
            end
            S_SFD: begin
               txd_q      <= SFD_NIBBLE;
               hi_phase_q <= 1'b0;
               state_q    <= S_DATA;
            end
            S_DATA: begin
               if (!hi_phase_q) begin
                  txd_q      <= cur.data[3:0];  // Low nibble first
                  hi_nib_q   <= cur.data[7:4];
                  last_q     <= cur.last;
                  crc_q      <= crc32_byte(crc_q, cur.data);
                  hi_phase_q <= 1'b1;
               end else begin
                  txd_q      <= hi_nib_q;
                  hi_phase_q <= 1'b0;
                  if (last_q) begin
                     cnt_q   <= '0;
                     state_q <= S_FCS;
                  end
               end
            end
            S_FCS: begin
               txd_q <= fcs[{cnt_q[2:0], 2'b00} +: 4];  // Lowest byte first
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 5'(FCS_NIBBLES - 1)) begin
                  cnt_q   <= '0;
                  state_q <= S_GAP;
               end
            end
            S_GAP: begin
               txd_q   <= '0;
               tx_en_q <= 1'b0;
               cnt_q   <= cnt_q + 1'b1;
               if (cnt_q == 5'(IPG_NIBBLES - 1)) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

endmodule

// File: project.f
+incdir+verification
common/eth_pkg.sv
common/byte_stream_if.sv
src/eth_frame_store.sv
eth_rx/eth_mii_rx.sv
eth_tx/eth_mii_tx.sv
src/eth_mac_top.sv
verification/tb_eth_mac.sv

// File: src/eth_frame_store.sv
/* Frame store
   Store-and-forward byte FIFO that releases complete frames only */
module eth_frame_store
   import eth_pkg::*;
#(
   parameter int INIT_CREDITS = 1
) (
   input logic              clk_i,
   input logic              rst_n_i,
   byte_stream_if.target    wr_if,
   byte_stream_if.initiator rd_if
);

   byte_beat_t mem [FRAME_STORE_DEPTH];

   logic [FRAME_STORE_ADDR_W-1:0] wr_ptr_q;
   logic [FRAME_STORE_ADDR_W-1:0] rd_ptr_q;
   logic [CREDIT_W-1:0]           frame_cnt_q;  // Complete frames held
   logic [CREDIT_W-1:0]           cred_q;       // Credits toward the reader
   logic                          rd_valid_q;
   byte_beat_t                    rd_beat_q;
   logic                          pop;
   logic                          frame_in;
   logic                          frame_out;

   assign pop       = (frame_cnt_q != '0) && (cred_q != '0);
   assign frame_in  = wr_if.valid && wr_if.beat.last;
   assign frame_out = pop && mem[rd_ptr_q].last;

   assign rd_if.valid  = rd_valid_q;
   assign rd_if.beat   = rd_beat_q;
   assign wr_if.credit = rd_valid_q;  // Slot freed by last cycle's pop

   // Byte storage and read register
   always_ff @(posedge clk_i) begin
      if (wr_if.valid) begin
         mem[wr_ptr_q] <= wr_if.beat;
      end
      if (pop) begin
         rd_beat_q <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         frame_cnt_q <= '0;
         cred_q      <= CREDIT_W'(INIT_CREDITS);
         rd_valid_q  <= 1'b0;
      end else begin
         rd_valid_q <= pop;
         if (wr_if.valid) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end

         case ({frame_in, frame_out})
            2'b10:   frame_cnt_q <= frame_cnt_q + 1'b1;
            2'b01:   frame_cnt_q <= frame_cnt_q - 1'b1;
            default: frame_cnt_q <= frame_cnt_q;  // Both or neither
         endcase

         case ({rd_if.credit, pop})
            2'b10:   cred_q <= cred_q + 1'b1;
            2'b01:   cred_q <= cred_q - 1'b1;
            default: cred_q <= cred_q;
         endcase
      end
   end

endmodule

// File: src/eth_mac_top.sv
/* Ethernet MAC frame engine top
   MII receive and transmit paths with a frame store on each side */
module eth_mac_top
   import eth_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   // Host transmit stream
   input  logic       tx_valid_i,
   input  logic [7:0] tx_data_i,
   input  logic       tx_last_i,
   output logic       tx_credit_o,
   // Host receive stream
   output logic       rx_valid_o,
   output logic [7:0] rx_data_o,
   output logic       rx_last_o,
   input  logic       rx_credit_i,
   // MII
   output logic [3:0] mii_txd_o,
   output logic       mii_tx_en_o,
   input  logic [3:0] mii_rxd_i,
   input  logic       mii_rx_dv_i,
   // Receive status pulses
   output logic       rx_frame_ok_o,
   output logic       rx_crc_err_o,
   output logic       rx_drop_o
);

   byte_stream_if host_tx_bus (.clk(clk_i));
   byte_stream_if mii_tx_bus  (.clk(clk_i));
   byte_stream_if mii_rx_bus  (.clk(clk_i));
   byte_stream_if host_rx_bus (.clk(clk_i));

   // Host ports onto the store streams
   assign host_tx_bus.valid = tx_valid_i;
   assign host_tx_bus.beat  = '{data: tx_data_i, last: tx_last_i};
   assign tx_credit_o       = host_tx_bus.credit;

   assign rx_valid_o         = host_rx_bus.valid;
   assign rx_data_o          = host_rx_bus.beat.data;
   assign rx_last_o          = host_rx_bus.beat.last;
   assign host_rx_bus.credit = rx_credit_i;

   eth_mii_rx rx (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .mii_rxd_i    (mii_rxd_i),
      .mii_rx_dv_i  (mii_rx_dv_i),
      .dst_if       (mii_rx_bus.initiator),
      .rx_frame_ok_o(rx_frame_ok_o),
      .rx_crc_err_o (rx_crc_err_o),
      .rx_drop_o    (rx_drop_o)
   );

   eth_frame_store #(
      .INIT_CREDITS(HOST_RX_CREDITS)
   ) rx_store (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wr_if  (mii_rx_bus.target),
      .rd_if  (host_rx_bus.initiator)
   );

   eth_frame_store #(
      .INIT_CREDITS(1)  // Matches the transmitter's single beat buffer
   ) tx_store (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wr_if  (host_tx_bus.target),
      .rd_if  (mii_tx_bus.initiator)
   );

   eth_mii_tx tx (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .src_if     (mii_tx_bus.target),
      .mii_txd_o  (mii_txd_o),
      .mii_tx_en_o(mii_tx_en_o)
   );

endmodule

// File: verification/eth_tb_checks.svh
/* Testbench helpers for the Ethernet MAC
   Typed compare tasks, reference CRC and MII frame builders */
`ifndef ETH_TB_CHECKS_SVH
`define ETH_TB_CHECKS_SVH

typedef logic [7:0] byte_q_t [$];
typedef logic [3:0] nib_q_t [$];

// Reflected CRC-32 one bit at a time
function automatic logic [31:0] crc_ref(input byte_q_t bytes);
   logic [31:0] crc;
   logic        fb;
   crc = 32'hFFFFFFFF;
   foreach (bytes[k]) begin
      for (int b = 0; b < 8; b++) begin
         fb  = crc[0] ^ bytes[k][b];
         crc = crc >> 1;
         if (fb) crc = crc ^ 32'hEDB88320;
      end
   end
   return crc;
endfunction

function automatic byte_q_t with_fcs(input byte_q_t payload);
   byte_q_t     q;
   logic [31:0] fcs;
   q   = payload;
   fcs = ~crc_ref(payload);
   for (int k = 0; k < 4; k++) q.push_back(fcs[8*k +: 8]);  // Low byte first
   return q;
endfunction

function automatic byte_q_t rand_payload(input int n);
   byte_q_t q;
   for (int k = 0; k < n; k++) q.push_back(8'($urandom));
   return q;
endfunction

// Nibbles expected on the wire while tx_en is high
function automatic nib_q_t mii_nibbles(input byte_q_t payload);
   nib_q_t  q;
   byte_q_t f;
   f = with_fcs(payload);
   for (int k = 0; k < 15; k++) q.push_back(4'h5);
   q.push_back(4'hD);
   foreach (f[k]) begin
      q.push_back(f[k][3:0]);
      q.push_back(f[k][7:4]);
   end
   return q;
endfunction

task automatic check_beat(input string name, input byte_beat_t exp, input byte_beat_t act);
   checks++;
   if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h/%b actual %h/%b", name,
               exp.data, exp.last, act.data, act.last);
   end
endtask

task automatic check_nibble(input string name, input logic [3:0] exp, input logic [3:0] act);
   checks++;
   if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
   end
endtask

task automatic check_count(input string name, input int exp, input int act);
   checks++;
   if (act != exp) begin
      errors++;
      $display("MISMATCH %s: expected %0d actual %0d", name, exp, act);
   end
endtask

// Lower bound on a clock count
task automatic check_at_least(input string name, input int min_exp, input int act);
   checks++;
   if (act < min_exp) begin
      errors++;
      $display("MISMATCH %s: expected at least %0d actual %0d", name, min_exp, act);
   end
endtask

// Status pulse counts since the last clear
task automatic check_status(input string name, input int exp_ok, input int exp_err,
                            input int exp_drop);
   checks++;
   if (ok_cnt != exp_ok || err_cnt != exp_err || drop_cnt != exp_drop) begin
      errors++;
      $display("MISMATCH %s: expected ok/err/drop %0d/%0d/%0d actual %0d/%0d/%0d", name,
               exp_ok, exp_err, exp_drop, ok_cnt, err_cnt, drop_cnt);
   end
endtask

`endif

// File: verification/tb_eth_mac.sv
/* Ethernet MAC testbench
   Directed transmit, receive, back-pressure and loopback tests */
module tb_eth_mac;
   import eth_pkg::*;

   localparam int LIMIT = 5000;  // Cycles per wait

   logic       clk_i;
   logic       rst_n_i;
   logic       tx_valid_i;
   logic [7:0] tx_data_i;
   logic       tx_last_i;
   logic       tx_credit_o;
   logic       rx_valid_o;
   logic [7:0] rx_data_o;
   logic       rx_last_o;
   logic       rx_credit_i;
   logic [3:0] mii_txd_o;
   logic       mii_tx_en_o;
   logic [3:0] mii_rxd_i;
   logic       mii_rx_dv_i;
   logic       rx_frame_ok_o;
   logic       rx_crc_err_o;
   logic       rx_drop_o;

   logic [3:0] drv_rxd;
   logic       drv_dv;
   logic       loop_en;
   logic       give_credits;

   int         errors;
   int         checks;
   int         ok_cnt;
   int         err_cnt;
   int         drop_cnt;
   int         tx_sent;
   int         tx_back;    // tx_credit_o pulses seen
   int         rx_got;
   int         rx_returned;
   int         tx_run;
   int         tx_gap;
   logic       tx_en_prev;
   logic       tx_seen_fall;
   byte_beat_t rx_beats [$];
   logic [3:0] tx_nibs [$];
   int         tx_lens [$];
   int         tx_gaps [$];

   `include "eth_tb_checks.svh"

   // Wire the transmitter back to the receiver in loopback
   assign mii_rxd_i   = loop_en ? mii_txd_o : drv_rxd;
   assign mii_rx_dv_i = loop_en ? mii_tx_en_o : drv_dv;

   eth_mac_top dut0 (.*);

   always #10 clk_i = ~clk_i;

   // Monitors sample on the falling edge
   always @(negedge clk_i) begin
      if (rx_valid_o) begin
         rx_beats.push_back('{data: rx_data_o, last: rx_last_o});
         rx_got++;
      end
      if (rx_frame_ok_o) ok_cnt++;
      if (rx_crc_err_o) err_cnt++;
      if (rx_drop_o) drop_cnt++;
      if (tx_credit_o) tx_back++;
      if (mii_tx_en_o) begin
         if (!tx_en_prev && tx_seen_fall) tx_gaps.push_back(tx_gap);
         tx_nibs.push_back(mii_txd_o);
         tx_run++;
      end else begin
         if (tx_en_prev) begin
            tx_lens.push_back(tx_run);
            tx_run       = 0;
            tx_gap       = 0;
            tx_seen_fall = 1'b1;
         end
         tx_gap++;
      end
      tx_en_prev = mii_tx_en_o;
   end

   // Host returns one credit per received beat when allowed
   always begin
      @(posedge clk_i);
      #2;
      if (give_credits && rx_got > rx_returned) begin
         rx_credit_i = 1'b1;
         rx_returned++;
      end else begin
         rx_credit_i = 1'b0;
      end
   end

   task automatic timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Test failures found");
      $finish;
   endtask

   task automatic clear_monitors();
      rx_beats.delete();
      tx_nibs.delete();
      tx_lens.delete();
      tx_gaps.delete();
      ok_cnt   = 0;
      err_cnt  = 0;
      drop_cnt = 0;
   endtask

   task automatic send_host_frame(input byte_q_t bytes);
      int t;
      foreach (bytes[k]) begin
         t = 0;
         while (FRAME_STORE_DEPTH - tx_sent + tx_back <= 0) begin
            @(posedge clk_i);
            #2;
            tx_valid_i = 1'b0;
            t++;
            if (t > LIMIT) timeout("transmit credit");
         end
         @(posedge clk_i);
         #2;
         tx_valid_i = 1'b1;
         tx_data_i  = bytes[k];
         tx_last_i  = (k == bytes.size() - 1);
         tx_sent++;
      end
      @(posedge clk_i);
      #2;
      tx_valid_i = 1'b0;
      tx_last_i  = 1'b0;
   endtask

   // Preamble, SFD, bytes low nibble first, then idle
   task automatic drive_mii(input byte_q_t bytes);
      nib_q_t q;
      for (int k = 0; k < 15; k++) q.push_back(4'h5);
      q.push_back(4'hD);
      foreach (bytes[k]) begin
         q.push_back(bytes[k][3:0]);
         q.push_back(bytes[k][7:4]);
      end
      foreach (q[k]) begin
         @(posedge clk_i);
         #2;
         drv_dv  = 1'b1;
         drv_rxd = q[k];
      end
      @(posedge clk_i);
      #2;
      drv_dv  = 1'b0;
      drv_rxd = 4'h0;
      repeat (12) @(posedge clk_i);
   endtask

   task automatic wait_tx_frames(input int n);
      int t;
      t = 0;
      while (tx_lens.size() < n) begin
         @(posedge clk_i);
         t++;
         if (t > LIMIT) timeout("tx_en to fall");
      end
   endtask

   task automatic wait_rx_beats(input int n);
      int t;
      t = 0;
      while (rx_beats.size() < n) begin
         @(posedge clk_i);
         t++;
         if (t > LIMIT) timeout("receive beats at the host");
      end
   endtask

   task automatic wait_status(input int n);
      int t;
      t = 0;
      while (ok_cnt + err_cnt + drop_cnt < n) begin
         @(posedge clk_i);
         t++;
         if (t > LIMIT) timeout("a receive status pulse");
      end
   endtask

   task automatic check_payload(input string name, input byte_q_t exp, input int base);
      foreach (exp[k]) begin
         check_beat(name, '{data: exp[k], last: (k == exp.size() - 1)}, rx_beats[base+k]);
      end
   endtask

   task automatic test_tx_format();
      byte_q_t p;
      nib_q_t  exp;
      clear_monitors();
      p   = rand_payload(20);
      exp = mii_nibbles(p);
      send_host_frame(p);
      wait_tx_frames(1);
      check_count("tx_format length", 15 + 1 + 2 * 20 + 8, tx_lens[0]);
      check_count("tx_format nibbles", exp.size(), tx_nibs.size());
      foreach (exp[k]) begin
         if (k < tx_nibs.size()) check_nibble("tx_format", exp[k], tx_nibs[k]);
      end
   endtask

   task automatic test_tx_gap();
      int back0;
      clear_monitors();
      back0 = tx_back;
      send_host_frame(rand_payload(10));
      send_host_frame(rand_payload(12));
      wait_tx_frames(2);
      repeat (4) @(posedge clk_i);
      check_count("tx_gap gaps seen", 2, tx_gaps.size());
      foreach (tx_gaps[k]) begin
         check_at_least("tx_gap", IPG_NIBBLES, tx_gaps[k]);
      end
      check_count("tx_gap credits", 22, tx_back - back0);
   endtask

   task automatic test_rx_good();
      byte_q_t p;
      clear_monitors();
      p = rand_payload(30);
      drive_mii(with_fcs(p));
      wait_status(1);
      wait_rx_beats(30);
      check_payload("rx_good", p, 0);
      check_status("rx_good status", 1, 0, 0);
   endtask

   task automatic test_rx_bad_fcs();
      byte_q_t p;
      byte_q_t f;
      clear_monitors();
      p = rand_payload(16);
      f = with_fcs(p);
      f[f.size() - 2][3] = ~f[f.size() - 2][3];  // One flipped FCS bit
      drive_mii(f);
      wait_status(1);
      wait_rx_beats(16);
      check_payload("rx_bad_fcs", p, 0);
      check_status("rx_bad_fcs status", 0, 1, 0);
      clear_monitors();
      drive_mii(rand_payload(3));
      wait_status(1);
      repeat (30) @(posedge clk_i);
      check_status("rx_short status", 0, 1, 0);
      check_count("rx_short beats", 0, rx_beats.size());
   endtask

   task automatic test_rx_reserve();
      byte_q_t p1;
      byte_q_t p2;
      clear_monitors();
      give_credits = 1'b0;
      p1 = rand_payload(100);
      p2 = rand_payload(100);
      drive_mii(with_fcs(p1));
      drive_mii(with_fcs(p2));
      drive_mii(with_fcs(rand_payload(100)));
      wait_status(3);
      check_status("rx_reserve status", 2, 0, 1);
      give_credits = 1'b1;
      wait_rx_beats(200);
      repeat (50) @(posedge clk_i);
      check_count("rx_reserve beats", 200, rx_beats.size());
      check_payload("rx_reserve first", p1, 0);
      check_payload("rx_reserve second", p2, 100);
   endtask

   task automatic test_loopback();
      byte_q_t p;
      clear_monitors();
      loop_en = 1'b1;
      p = rand_payload(40);
      send_host_frame(p);
      wait_status(1);
      wait_rx_beats(40);
      check_payload("loopback", p, 0);
      check_status("loopback status", 1, 0, 0);
      wait_tx_frames(1);
      loop_en = 1'b0;
   endtask

   initial begin
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      tx_valid_i   = 1'b0;
      tx_data_i    = 8'h00;
      tx_last_i    = 1'b0;
      rx_credit_i  = 1'b0;
      drv_rxd      = 4'h0;
      drv_dv       = 1'b0;
      loop_en      = 1'b0;
      give_credits = 1'b1;
      tx_en_prev   = 1'b0;
      tx_seen_fall = 1'b0;
      void'($urandom(35));
      repeat (16) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      repeat (4) @(posedge clk_i);

      test_tx_format();
      test_tx_gap();
      test_rx_good();
      test_rx_bad_fcs();
      test_rx_reserve();
      test_loopback();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
